/* dv/id_stage_stim.txt */
# columns: test inst rs1d rs2d csrd ex_addr ex_data mem_addr mem_data stall_cycles
#   then expected: rs1 rs2 rd csr rs1d rs2d imm csr_imm csr_imm_valid csrd alu exc mem pc csr_op trap
#
# decode and immediates
addi     ffc10093 11 22 33 0  ee 0  dd 0  2  0  1  0   11 22 fffffffffffffffc 2  0 33 1 8 0 0 0 0
lui      123451b7 11 22 33 8  ee 3  dd 0  0  0  3  0   11 22 12345000         8  0 33 1 2 0 0 0 0
auipc    fffff217 11 22 33 0  ee 0  dd 0  0  0  4  0   11 22 fffffffffffff000 1f 0 33 1 1 0 0 0 0
jal      ff1ff0ef 11 22 33 0  ee 0  dd 0  0  0  1  0   11 22 fffffffffffffff0 1f 0 33 1 3 0 2 0 0
bne      00629463 11 22 33 0  ee 0  dd 0  5  6  0  0   11 22 8                5  0 33 f 7 0 1 0 0
sd       fe713c23 11 22 33 0  ee 0  dd 0  2  7  0  0   11 22 fffffffffffffff8 2  0 33 1 6 b 0 0 0
lwu      01056483 11 22 33 0  ee 0  dd 0  a  0  9  0   11 22 10               a  0 33 1 5 6 0 0 0
sraiw    4036559b 11 22 33 0  ee 0  dd 0  c  0  b  0   11 22 403              c  0 33 b 9 0 0 0 0
#
# index gating and csr
csrrsi   3002e6f3 11 22 44 5  ee 0  dd 0  0  0  d  300 11 22 300              5  1 44 1 c 0 0 3 0
csrrs    34202773 11 22 55 0  ee 0  dd 0  0  0  e  342 11 22 342              0  0 55 1 c 0 0 1 0
csrrw    305817f3 11 22 66 0  ee 0  dd 0  10 0  f  305 11 22 305              10 0 66 1 c 0 0 2 0
#
# forwarding priority
fwd_both 016a8a33 11 22 33 15 ee 15 dd 0  15 16 14 0   ee 22 0                15 0 33 1 a 0 0 0 0
fwd_mem  016a8a33 11 22 33 3  ee 16 dd 0  15 16 14 0   11 dd 0                15 0 33 1 a 0 0 0 0
fwd_x0   01600a33 11 22 33 0  ee 0  dd 0  0  16 14 0   11 22 0                0  0 33 1 a 0 0 0 0
#
# load-use stall
ld       00033283 11 22 33 0  ee 0  dd 0  6  0  5  0   11 22 0                6  0 33 1 5 7 0 0 0
ld_use   008283b3 11 22 33 5  ee 0  dd 1  5  8  7  0   ee 22 0                5  0 33 1 a 0 0 0 0
#
# traps
ecall    00000073 11 22 33 0  ee 0  dd 0  0  0  0  0   11 22 0                0  0 33 0 0 0 4 0 4
ebreak   00100073 11 22 33 0  ee 0  dd 0  0  0  0  0   11 22 1                0  0 33 0 d 0 0 0 2
mret     30200073 11 22 33 0  ee 0  dd 0  0  0  0  0   11 22 302              0  0 33 0 0 0 4 0 1

/* dv/id_stage_tb.sv */
`timescale 1ns/1ns
`include "rv_defs.svh"

module id_stage_tb import pipe_ctrl_pkg::*; ();

  localparam int HALF_PERIOD = 4;
  localparam int STALL_LIMIT = 4;
  localparam int NUM_COLS    = 25;
  // ld x5, 0(x6) sits in decode while reset is held
  localparam logic [`RV_INST_W-1:0] RESET_INST = 32'h00033283;

  logic                  clk;
  logic                  reset;
  logic [`RV_INST_W-1:0] inst;
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   rs2_data;
  logic [`RV_XLEN-1:0]   csr_data;
  logic [`RV_REG_AW-1:0] ex_rd_addr;
  logic [`RV_XLEN-1:0]   ex_rd_data;
  logic [`RV_REG_AW-1:0] mem_rd_addr;
  logic [`RV_XLEN-1:0]   mem_rd_data;

  logic [`RV_REG_AW-1:0] rs1_idx;
  logic [`RV_REG_AW-1:0] rs2_idx;
  logic                  stall;
  logic [`RV_REG_AW-1:0] id_ex_rs1_idx;
  logic [`RV_REG_AW-1:0] id_ex_rs2_idx;
  logic [`RV_REG_AW-1:0] id_ex_rd_idx;
  logic [`RV_CSR_AW-1:0] id_ex_csr_idx;
  logic [`RV_XLEN-1:0]   id_ex_rs1_data;
  logic [`RV_XLEN-1:0]   id_ex_rs2_data;
  logic [`RV_XLEN-1:0]   id_ex_imm;
  logic [`RV_XLEN-1:0]   id_ex_csr_imm;
  logic                  id_ex_csr_imm_valid;
  logic [`RV_XLEN-1:0]   id_ex_csr_data;
  alu_op_e               id_ex_alu_op;
  exc_op_e               id_ex_exc_op;
  mem_op_e               id_ex_mem_op;
  pc_op_e                id_ex_pc_op;
  csr_op_e               id_ex_csr_op;
  trap_flags_t           id_ex_trap;

  // fields of one stim line with inputs, stall count and expected id_ex values
  logic [63:0]     col [0:NUM_COLS-1];
  string           test_name;
  logic [8*160-1:0] line_rest;
  int              fd;
  int              code;
  int              error_count;
  int              test_count;
  int              failed_tests;
  logic            stop_run;

  id_stage dut0 (
    .clk_i                 (clk),
    .reset_i               (reset),
    .inst_i                (inst),
    .rs1_data_i            (rs1_data),
    .rs2_data_i            (rs2_data),
    .csr_data_i            (csr_data),
    .ex_rd_addr_i          (ex_rd_addr),
    .ex_rd_data_i          (ex_rd_data),
    .mem_rd_addr_i         (mem_rd_addr),
    .mem_rd_data_i         (mem_rd_data),
    .rs1_idx_o             (rs1_idx),
    .rs2_idx_o             (rs2_idx),
    .stall_o               (stall),
    .id_ex_rs1_idx_o       (id_ex_rs1_idx),
    .id_ex_rs2_idx_o       (id_ex_rs2_idx),
    .id_ex_rd_idx_o        (id_ex_rd_idx),
    .id_ex_csr_idx_o       (id_ex_csr_idx),
    .id_ex_rs1_data_o      (id_ex_rs1_data),
    .id_ex_rs2_data_o      (id_ex_rs2_data),
    .id_ex_imm_o           (id_ex_imm),
    .id_ex_csr_imm_o       (id_ex_csr_imm),
    .id_ex_csr_imm_valid_o (id_ex_csr_imm_valid),
    .id_ex_csr_data_o      (id_ex_csr_data),
    .id_ex_alu_op_o        (id_ex_alu_op),
    .id_ex_exc_op_o        (id_ex_exc_op),
    .id_ex_mem_op_o        (id_ex_mem_op),
    .id_ex_pc_op_o         (id_ex_pc_op),
    .id_ex_csr_op_o        (id_ex_csr_op),
    .id_ex_trap_o          (id_ex_trap)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  task automatic check_value(input string sig, input logic [63:0] got,
                             input logic [63:0] exp);
    begin
      if (got !== exp) begin
        $display("MISMATCH %s: got %0h expected %0h", sig, got, exp);
        error_count++;
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    begin
      test_count++;
      if (error_count == errs_before) begin
        $display("test %s: ok", name);
      end else begin
        $display("test %s: FAILED", name);
        failed_tests++;
      end
    end
  endtask

  // control fields of an empty slot in ID/EX
  task automatic check_bubble;
    begin
      check_value("id_ex_rs1_idx_o", id_ex_rs1_idx, 0);
      check_value("id_ex_rs2_idx_o", id_ex_rs2_idx, 0);
      check_value("id_ex_rd_idx_o", id_ex_rd_idx, 0);
      check_value("id_ex_csr_idx_o", id_ex_csr_idx, 0);
      check_value("id_ex_imm_o", id_ex_imm, 0);
      check_value("id_ex_csr_imm_o", id_ex_csr_imm, 0);
      check_value("id_ex_csr_imm_valid_o", id_ex_csr_imm_valid, 0);
      check_value("id_ex_alu_op_o", id_ex_alu_op, ALU_NONE);
      check_value("id_ex_exc_op_o", id_ex_exc_op, EXC_NONE);
      check_value("id_ex_mem_op_o", id_ex_mem_op, MEM_NONE);
      check_value("id_ex_pc_op_o", id_ex_pc_op, PC_INC4);
      check_value("id_ex_csr_op_o", id_ex_csr_op, CSR_NONE);
      check_value("id_ex_trap_o", id_ex_trap, 0);
    end
  endtask

  task automatic check_expected;
    begin
      check_value("id_ex_rs1_idx_o", id_ex_rs1_idx, col[9]);
      check_value("id_ex_rs2_idx_o", id_ex_rs2_idx, col[10]);
      check_value("id_ex_rd_idx_o", id_ex_rd_idx, col[11]);
      check_value("id_ex_csr_idx_o", id_ex_csr_idx, col[12]);
      check_value("id_ex_rs1_data_o", id_ex_rs1_data, col[13]);
      check_value("id_ex_rs2_data_o", id_ex_rs2_data, col[14]);
      check_value("id_ex_imm_o", id_ex_imm, col[15]);
      check_value("id_ex_csr_imm_o", id_ex_csr_imm, col[16]);
      check_value("id_ex_csr_imm_valid_o", id_ex_csr_imm_valid, col[17]);
      check_value("id_ex_csr_data_o", id_ex_csr_data, col[18]);
      check_value("id_ex_alu_op_o", id_ex_alu_op, col[19]);
      check_value("id_ex_exc_op_o", id_ex_exc_op, col[20]);
      check_value("id_ex_mem_op_o", id_ex_mem_op, col[21]);
      check_value("id_ex_pc_op_o", id_ex_pc_op, col[22]);
      check_value("id_ex_csr_op_o", id_ex_csr_op, col[23]);
      check_value("id_ex_trap_o", id_ex_trap, col[24]);
    end
  endtask

  // starts and ends on a falling edge
  task automatic run_vector;
    int errs_before;
    int stall_cycles;
    begin
      errs_before  = error_count;
      stall_cycles = 0;
      inst        = col[0][`RV_INST_W-1:0];
      rs1_data    = col[1];
      rs2_data    = col[2];
      csr_data    = col[3];
      ex_rd_addr  = col[4][`RV_REG_AW-1:0];
      ex_rd_data  = col[5];
      mem_rd_addr = col[6][`RV_REG_AW-1:0];
      mem_rd_data = col[7];
      #1;
      check_value("rs1_idx_o", rs1_idx, col[9]);
      check_value("rs2_idx_o", rs2_idx, col[10]);
      check_value("stall_o", stall, col[8] != 0);
      // instruction held while one bubble enters per stalled cycle
      while (stall === 1'b1 && !stop_run) begin
        @(posedge clk);
        @(negedge clk);
        stall_cycles++;
        check_bubble();
        if (stall_cycles >= STALL_LIMIT && stall === 1'b1) begin
          $display("timeout: stall_o still high after %0d cycles in test %s",
                   stall_cycles, test_name);
          error_count++;
          stop_run = 1'b1;
        end
      end
      if (!stop_run) begin
        check_value("stall cycles", stall_cycles, col[8]);
        @(posedge clk);
        @(negedge clk);
        check_expected();
      end
      report_test(test_name, errs_before);
    end
  endtask

  initial begin
    reset        = 1'b1;
    inst         = RESET_INST;
    rs1_data     = '0;
    rs2_data     = '0;
    csr_data     = '0;
    ex_rd_addr   = '0;
    ex_rd_data   = '0;
    mem_rd_addr  = '0;
    mem_rd_data  = '0;
    error_count  = 0;
    test_count   = 0;
    failed_tests = 0;
    stop_run     = 1'b0;

    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // nothing captured yet so only the reset state is visible
    check_value("id_ex_exc_op_o", id_ex_exc_op, EXC_NONE);
    check_value("id_ex_mem_op_o", id_ex_mem_op, MEM_NONE);
    check_value("id_ex_csr_op_o", id_ex_csr_op, CSR_NONE);
    check_value("id_ex_pc_op_o", id_ex_pc_op, PC_INC4);
    check_value("id_ex_trap_o", id_ex_trap, 0);
    report_test("reset", 0);

    fd = $fopen("dv/id_stage_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file dv/id_stage_stim.txt");
      error_count++;
    end else begin
      code = $fscanf(fd, "%s", test_name);
      while (code == 1 && !stop_run) begin
        if (test_name == "#") begin
          code = $fgets(line_rest, fd);
        end else begin
          code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                         col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                         col[7], col[8], col[9], col[10], col[11], col[12]);
          code += $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                          col[13], col[14], col[15], col[16], col[17], col[18],
                          col[19], col[20], col[21], col[22], col[23], col[24]);
          if (code != NUM_COLS) begin
            $display("stimulus line %s is malformed, read %0d of %0d fields",
                     test_name, code, NUM_COLS);
            error_count++;
            stop_run = 1'b1;
          end else begin
            run_vector();
          end
        end
        code = $fscanf(fd, "%s", test_name);
      end
      $fclose(fd);
    end

    $display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests,
             error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* id_stage.f */
+incdir+logic
logic/rv_isa_pkg.sv
logic/pipe_ctrl_pkg.sv
logic/opcode_classify.sv
logic/imm_gen.sv
logic/ctrl_encode.sv
logic/operand_bypass.sv
logic/id_ex_reg.sv
logic/id_stage.sv
dv/id_stage_tb.sv

/* logic/ctrl_encode.sv */
`timescale 1ns/1ns

module ctrl_encode import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
  input  rv_inst_u     inst_i,
  input  rv_opgrp_e    opgrp_i,
  input  logic         csr_access_i,
  output alu_op_e      alu_op_o,
  output exc_op_e      exc_op_o,
  output mem_op_e      mem_op_o,
  output pc_op_e       pc_op_o,
  output csr_op_e      csr_op_o,
  output trap_flags_t  trap_o
);

  logic [2:0]  f3;
  logic [6:0]  f7;
  logic        sys_plain;
  logic        is_ecall;
  logic        is_ebreak;
  logic        is_mret;

  assign f3 = inst_i.r.funct3;
  assign f7 = inst_i.r.funct7;

  // privileged ops share funct3 000 and differ in the 12-bit field
  assign sys_plain = (opgrp_i == GRP_SYSTEM) && (f3 == 3'b000);
  assign is_ecall  = sys_plain && (inst_i.i.imm11_0 == 12'h000);
  assign is_ebreak = sys_plain && (inst_i.i.imm11_0 == 12'h001);
  assign is_mret   = sys_plain && (inst_i.i.imm11_0 == 12'h302);

  always_comb begin
    alu_op_o = ALU_NONE;
    case (opgrp_i)
      GRP_LOAD, GRP_STORE, GRP_JAL, GRP_JALR, GRP_AUIPC, GRP_LUI: alu_op_o = ALU_ADD;
      GRP_SYSTEM: if (csr_access_i) alu_op_o = ALU_ADD;
      GRP_BRANCH: begin
        case (f3)
          3'b000: alu_op_o = ALU_BEQ;
          3'b001: alu_op_o = ALU_BNE;
          3'b100: alu_op_o = ALU_BLT;
          3'b101: alu_op_o = ALU_BGE;
          3'b110: alu_op_o = ALU_BLTU;
          3'b111: alu_op_o = ALU_BGEU;
          default: alu_op_o = ALU_NONE;
        endcase
      end
      GRP_OP_IMM: begin
        case (f3)
          3'b000: alu_op_o = ALU_ADD;
          3'b010: alu_op_o = ALU_SLT;
          3'b011: alu_op_o = ALU_SLTU;
          3'b100: alu_op_o = ALU_XOR;
          3'b110: alu_op_o = ALU_OR;
          3'b111: alu_op_o = ALU_AND;
          // 6-bit shamt leaves only funct7[6:1] as opcode
          3'b001: if (f7[6:1] == 6'b000000) alu_op_o = ALU_SLL;
          3'b101: begin
            if (f7[6:1] == 6'b000000) alu_op_o = ALU_SRL;
            else if (f7[6:1] == 6'b010000) alu_op_o = ALU_SRA;
          end
          default: alu_op_o = ALU_NONE;
        endcase
      end
      GRP_OP: begin
        case ({f7, f3})
          {7'b0000000, 3'b000}: alu_op_o = ALU_ADD;
          {7'b0100000, 3'b000}: alu_op_o = ALU_SUB;
          {7'b0000000, 3'b001}: alu_op_o = ALU_SLL;
          {7'b0000000, 3'b010}: alu_op_o = ALU_SLT;
          {7'b0000000, 3'b011}: alu_op_o = ALU_SLTU;
          {7'b0000000, 3'b100}: alu_op_o = ALU_XOR;
          {7'b0000000, 3'b101}: alu_op_o = ALU_SRL;
          {7'b0100000, 3'b101}: alu_op_o = ALU_SRA;
          {7'b0000000, 3'b110}: alu_op_o = ALU_OR;
          {7'b0000000, 3'b111}: alu_op_o = ALU_AND;
          default: alu_op_o = ALU_NONE;
        endcase
      end
      GRP_OP_IMM32, GRP_OP32: begin
        // execute sign-extends the word result
        case ({f7, f3})
          {7'b0000000, 3'b001}: alu_op_o = ALU_SLLW;
          {7'b0000000, 3'b101}: alu_op_o = ALU_SRLW;
          {7'b0100000, 3'b101}: alu_op_o = ALU_SRAW;
          {7'b0100000, 3'b000}: begin
            if (opgrp_i == GRP_OP32) alu_op_o = ALU_SUB;
            else alu_op_o = ALU_ADD;
          end
          default: if (f3 == 3'b000 && (opgrp_i == GRP_OP_IMM32 || f7 == 7'b0))
                     alu_op_o = ALU_ADD;
        endcase
      end
      default: alu_op_o = ALU_NONE;
    endcase
  end

  always_comb begin
    case (opgrp_i)
      GRP_AUIPC:    exc_op_o = EXC_AUIPC;
      GRP_LUI:      exc_op_o = EXC_LUI;
      GRP_JAL:      exc_op_o = EXC_JAL;
      GRP_JALR:     exc_op_o = EXC_JALR;
      GRP_LOAD:     exc_op_o = EXC_LOAD;
      GRP_STORE:    exc_op_o = EXC_STORE;
      GRP_BRANCH:   exc_op_o = EXC_BRANCH;
      GRP_OP_IMM:   exc_op_o = EXC_OPIMM;
      GRP_OP_IMM32: exc_op_o = EXC_OPIMM32;
      GRP_OP:       exc_op_o = EXC_OP;
      GRP_OP32:     exc_op_o = EXC_OP32;
      GRP_SYSTEM:   exc_op_o = csr_access_i ? EXC_CSR : (is_ebreak ? EXC_EBREAK : EXC_NONE);
      default:      exc_op_o = EXC_NONE;
    endcase
  end

  always_comb begin
    mem_op_o = MEM_NONE;
    if (opgrp_i == GRP_LOAD) begin
      case (f3)
        3'b000: mem_op_o = MEM_LB;
        3'b001: mem_op_o = MEM_LH;
        3'b010: mem_op_o = MEM_LW;
        3'b011: mem_op_o = MEM_LD;
        3'b100: mem_op_o = MEM_LBU;
        3'b101: mem_op_o = MEM_LHU;
        3'b110: mem_op_o = MEM_LWU;
        default: mem_op_o = MEM_NONE;
      endcase
    end else if (opgrp_i == GRP_STORE) begin
      case (f3)
        3'b000: mem_op_o = MEM_SB;
        3'b001: mem_op_o = MEM_SH;
        3'b010: mem_op_o = MEM_SW;
        3'b011: mem_op_o = MEM_SD;
        default: mem_op_o = MEM_NONE;
      endcase
    end
  end

  always_comb begin
    if (opgrp_i == GRP_BRANCH) pc_op_o = PC_BRANCH;
    else if (opgrp_i == GRP_JAL) pc_op_o = PC_JAL;
    else if (opgrp_i == GRP_JALR) pc_op_o = PC_JALR;
    else if (is_ecall || is_mret) pc_op_o = PC_TRAP;
    else pc_op_o = PC_INC4;
  end

  // set/clear with x0 or uimm 0 only reads the csr
  always_comb begin
    csr_op_o = CSR_NONE;
    if (csr_access_i) begin
      if (f3[1] && inst_i.i.rs1 == '0) csr_op_o = CSR_READ;
      else if (f3[1:0] == 2'b01) csr_op_o = CSR_WRITE;
      else if (f3[1:0] == 2'b10) csr_op_o = CSR_SET;
      else csr_op_o = CSR_CLEAR;
    end
  end

  assign trap_o.ecall  = is_ecall;
  assign trap_o.ebreak = is_ebreak;
  assign trap_o.mret   = is_mret;

endmodule

/* logic/id_ex_reg.sv */
`timescale 1ns/1ns
`include "rv_defs.svh"

module id_ex_reg import pipe_ctrl_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  stall_i,
  input  logic [`RV_REG_AW-1:0] rs1_idx_i,
  input  logic [`RV_REG_AW-1:0] rs2_idx_i,
  input  logic [`RV_REG_AW-1:0] rd_idx_i,
  input  logic [`RV_CSR_AW-1:0] csr_idx_i,
  input  logic [`RV_XLEN-1:0]   rs1_data_i,
  input  logic [`RV_XLEN-1:0]   rs2_data_i,
  input  logic [`RV_XLEN-1:0]   imm_i,
  input  logic [`RV_XLEN-1:0]   csr_imm_i,
  input  logic                  csr_imm_valid_i,
  input  logic [`RV_XLEN-1:0]   csr_data_i,
  input  alu_op_e               alu_op_i,
  input  exc_op_e               exc_op_i,
  input  mem_op_e               mem_op_i,
  input  pc_op_e                pc_op_i,
  input  csr_op_e               csr_op_i,
  input  trap_flags_t           trap_i,
  output logic [`RV_REG_AW-1:0] id_ex_rs1_idx_o,
  output logic [`RV_REG_AW-1:0] id_ex_rs2_idx_o,
  output logic [`RV_REG_AW-1:0] id_ex_rd_idx_o,
  output logic [`RV_CSR_AW-1:0] id_ex_csr_idx_o,
  output logic [`RV_XLEN-1:0]   id_ex_rs1_data_o,
  output logic [`RV_XLEN-1:0]   id_ex_rs2_data_o,
  output logic [`RV_XLEN-1:0]   id_ex_imm_o,
  output logic [`RV_XLEN-1:0]   id_ex_csr_imm_o,
  output logic                  id_ex_csr_imm_valid_o,
  output logic [`RV_XLEN-1:0]   id_ex_csr_data_o,
  output alu_op_e               id_ex_alu_op_o,
  output exc_op_e               id_ex_exc_op_o,
  output mem_op_e               id_ex_mem_op_o,
  output pc_op_e                id_ex_pc_op_o,
  output csr_op_e               id_ex_csr_op_o,
  output trap_flags_t           id_ex_trap_o
);

  // control fields, bubble on reset or stall
  always_ff @(posedge clk_i) begin
    if (reset_i || stall_i) begin
      id_ex_rs1_idx_o       <= '0;
      id_ex_rs2_idx_o       <= '0;
      id_ex_rd_idx_o        <= '0;
      id_ex_csr_idx_o       <= '0;
      id_ex_imm_o           <= '0;
      id_ex_csr_imm_o       <= '0;
      id_ex_csr_imm_valid_o <= 1'b0;
      id_ex_alu_op_o        <= ALU_NONE;
      id_ex_exc_op_o        <= EXC_NONE;
      id_ex_mem_op_o        <= MEM_NONE;
      id_ex_pc_op_o         <= PC_INC4;
      id_ex_csr_op_o        <= CSR_NONE;
      id_ex_trap_o          <= '0;
    end else begin
      id_ex_rs1_idx_o       <= rs1_idx_i;
      id_ex_rs2_idx_o       <= rs2_idx_i;
      id_ex_rd_idx_o        <= rd_idx_i;
      id_ex_csr_idx_o       <= csr_idx_i;
      id_ex_imm_o           <= imm_i;
      id_ex_csr_imm_o       <= csr_imm_i;
      id_ex_csr_imm_valid_o <= csr_imm_valid_i;
      id_ex_alu_op_o        <= alu_op_i;
      id_ex_exc_op_o        <= exc_op_i;
      id_ex_mem_op_o        <= mem_op_i;
      id_ex_pc_op_o         <= pc_op_i;
      id_ex_csr_op_o        <= csr_op_i;
      id_ex_trap_o          <= trap_i;
    end
  end

  // operand data, qualified by the control fields downstream
  always_ff @(posedge clk_i) begin
    id_ex_rs1_data_o <= rs1_data_i;
    id_ex_rs2_data_o <= rs2_data_i;
    id_ex_csr_data_o <= csr_data_i;
  end

endmodule

/* logic/id_stage.sv */
`timescale 1ns/1ns
`include "rv_defs.svh"

module id_stage import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  rv_inst_u              inst_i,
  input  logic [`RV_XLEN-1:0]   rs1_data_i,
  input  logic [`RV_XLEN-1:0]   rs2_data_i,
  input  logic [`RV_XLEN-1:0]   csr_data_i,
  input  logic [`RV_REG_AW-1:0] ex_rd_addr_i,
  input  logic [`RV_XLEN-1:0]   ex_rd_data_i,
  input  logic [`RV_REG_AW-1:0] mem_rd_addr_i,
  input  logic [`RV_XLEN-1:0]   mem_rd_data_i,
  output logic [`RV_REG_AW-1:0] rs1_idx_o,
  output logic [`RV_REG_AW-1:0] rs2_idx_o,
  output logic                  stall_o,
  output logic [`RV_REG_AW-1:0] id_ex_rs1_idx_o,
  output logic [`RV_REG_AW-1:0] id_ex_rs2_idx_o,
  output logic [`RV_REG_AW-1:0] id_ex_rd_idx_o,
  output logic [`RV_CSR_AW-1:0] id_ex_csr_idx_o,
  output logic [`RV_XLEN-1:0]   id_ex_rs1_data_o,
  output logic [`RV_XLEN-1:0]   id_ex_rs2_data_o,
  output logic [`RV_XLEN-1:0]   id_ex_imm_o,
  output logic [`RV_XLEN-1:0]   id_ex_csr_imm_o,
  output logic                  id_ex_csr_imm_valid_o,
  output logic [`RV_XLEN-1:0]   id_ex_csr_data_o,
  output alu_op_e               id_ex_alu_op_o,
  output exc_op_e               id_ex_exc_op_o,
  output mem_op_e               id_ex_mem_op_o,
  output pc_op_e                id_ex_pc_op_o,
  output csr_op_e               id_ex_csr_op_o,
  output trap_flags_t           id_ex_trap_o
);

  rv_opgrp_e              opgrp;
  rv_fmt_e                fmt;
  logic [`RV_REG_AW-1:0]  rd_idx;
  logic [`RV_CSR_AW-1:0]  csr_idx;
  logic                   csr_imm_valid;
  logic                   csr_access;
  logic [`RV_XLEN-1:0]    imm;
  logic [`RV_XLEN-1:0]    csr_imm;
  logic [`RV_XLEN-1:0]    rs1_fwd;
  logic [`RV_XLEN-1:0]    rs2_fwd;
  alu_op_e                alu_op;
  exc_op_e                exc_op;
  mem_op_e                mem_op;
  pc_op_e                 pc_op;
  csr_op_e                csr_op;
  trap_flags_t            trap;

  opcode_classify classify0 (
    .inst_i          (inst_i),
    .opgrp_o         (opgrp),
    .fmt_o           (fmt),
    .rs1_idx_o       (rs1_idx_o),
    .rs2_idx_o       (rs2_idx_o),
    .rd_idx_o        (rd_idx),
    .csr_idx_o       (csr_idx),
    .csr_imm_valid_o (csr_imm_valid),
    .csr_access_o    (csr_access)
  );

  imm_gen imm0 (
    .inst_i    (inst_i),
    .fmt_i     (fmt),
    .imm_o     (imm),
    .csr_imm_o (csr_imm)
  );

  ctrl_encode ctrl0 (
    .inst_i       (inst_i),
    .opgrp_i      (opgrp),
    .csr_access_i (csr_access),
    .alu_op_o     (alu_op),
    .exc_op_o     (exc_op),
    .mem_op_o     (mem_op),
    .pc_op_o      (pc_op),
    .csr_op_o     (csr_op),
    .trap_o       (trap)
  );

  // previous instruction class comes back from the stage register
  operand_bypass bypass0 (
    .rs1_idx_i     (rs1_idx_o),
    .rs2_idx_i     (rs2_idx_o),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .ex_rd_addr_i  (ex_rd_addr_i),
    .ex_rd_data_i  (ex_rd_data_i),
    .mem_rd_addr_i (mem_rd_addr_i),
    .mem_rd_data_i (mem_rd_data_i),
    .prev_exc_op_i (id_ex_exc_op_o),
    .rs1_fwd_o     (rs1_fwd),
    .rs2_fwd_o     (rs2_fwd),
    .stall_o       (stall_o)
  );

  id_ex_reg id_ex0 (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .stall_i               (stall_o),
    .rs1_idx_i             (rs1_idx_o),
    .rs2_idx_i             (rs2_idx_o),
    .rd_idx_i              (rd_idx),
    .csr_idx_i             (csr_idx),
    .rs1_data_i            (rs1_fwd),
    .rs2_data_i            (rs2_fwd),
    .imm_i                 (imm),
    .csr_imm_i             (csr_imm),
    .csr_imm_valid_i       (csr_imm_valid),
    .csr_data_i            (csr_data_i),
    .alu_op_i              (alu_op),
    .exc_op_i              (exc_op),
    .mem_op_i              (mem_op),
    .pc_op_i               (pc_op),
    .csr_op_i              (csr_op),
    .trap_i                (trap),
    .id_ex_rs1_idx_o       (id_ex_rs1_idx_o),
    .id_ex_rs2_idx_o       (id_ex_rs2_idx_o),
    .id_ex_rd_idx_o        (id_ex_rd_idx_o),
    .id_ex_csr_idx_o       (id_ex_csr_idx_o),
    .id_ex_rs1_data_o      (id_ex_rs1_data_o),
    .id_ex_rs2_data_o      (id_ex_rs2_data_o),
    .id_ex_imm_o           (id_ex_imm_o),
    .id_ex_csr_imm_o       (id_ex_csr_imm_o),
    .id_ex_csr_imm_valid_o (id_ex_csr_imm_valid_o),
    .id_ex_csr_data_o      (id_ex_csr_data_o),
    .id_ex_alu_op_o        (id_ex_alu_op_o),
    .id_ex_exc_op_o        (id_ex_exc_op_o),
    .id_ex_mem_op_o        (id_ex_mem_op_o),
    .id_ex_pc_op_o         (id_ex_pc_op_o),
    .id_ex_csr_op_o        (id_ex_csr_op_o),
    .id_ex_trap_o          (id_ex_trap_o)
  );

endmodule

/* logic/imm_gen.sv */
`timescale 1ns/1ns
`include "rv_defs.svh"

module imm_gen import rv_isa_pkg::*; (
  input  rv_inst_u              inst_i,
  input  rv_fmt_e               fmt_i,
  output logic [`RV_XLEN-1:0]   imm_o,
  output logic [`RV_XLEN-1:0]   csr_imm_o
);

  always_comb begin
    case (fmt_i)
      FMT_I: imm_o = {{(`RV_XLEN-12){inst_i.i.imm11_0[11]}}, inst_i.i.imm11_0};
      FMT_S: imm_o = {{(`RV_XLEN-12){inst_i.s.imm11_5[6]}}, inst_i.s.imm11_5,
                      inst_i.s.imm4_0};
      FMT_B: imm_o = {{(`RV_XLEN-12){inst_i.b.imm12}}, inst_i.b.imm11,
                      inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};
      // upper 20 bits land at 31:12 then sign-extend past the word
      FMT_U: imm_o = {{(`RV_XLEN-`RV_INST_W){inst_i.u.imm31_12[19]}},
                      inst_i.u.imm31_12, 12'b0};
      FMT_J: imm_o = {{(`RV_XLEN-20){inst_i.j.imm20}}, inst_i.j.imm19_12,
                      inst_i.j.imm11, inst_i.j.imm10_1, 1'b0};
      default: imm_o = '0;
    endcase
  end

  // uimm for csrr*i, zero-extended
  assign csr_imm_o = {{(`RV_XLEN-5){1'b0}}, inst_i.i.rs1};

endmodule

/* logic/opcode_classify.sv */
`timescale 1ns/1ns
`include "rv_defs.svh"

module opcode_classify import rv_isa_pkg::*; (
  input  rv_inst_u               inst_i,
  output rv_opgrp_e              opgrp_o,
  output rv_fmt_e                fmt_o,
  output logic [`RV_REG_AW-1:0]  rs1_idx_o,
  output logic [`RV_REG_AW-1:0]  rs2_idx_o,
  output logic [`RV_REG_AW-1:0]  rd_idx_o,
  output logic [`RV_CSR_AW-1:0]  csr_idx_o,
  output logic                   csr_imm_valid_o,
  output logic                   csr_access_o
);

  logic need_rs1;
  logic need_rs2;
  logic need_rd;

  always_comb begin
    case (inst_i.r.opcode)
      OPC_LOAD:     opgrp_o = GRP_LOAD;
      OPC_STORE:    opgrp_o = GRP_STORE;
      OPC_BRANCH:   opgrp_o = GRP_BRANCH;
      OPC_JALR:     opgrp_o = GRP_JALR;
      OPC_JAL:      opgrp_o = GRP_JAL;
      OPC_OP_IMM:   opgrp_o = GRP_OP_IMM;
      OPC_OP:       opgrp_o = GRP_OP;
      OPC_OP_IMM32: opgrp_o = GRP_OP_IMM32;
      OPC_OP32:     opgrp_o = GRP_OP32;
      OPC_AUIPC:    opgrp_o = GRP_AUIPC;
      OPC_LUI:      opgrp_o = GRP_LUI;
      OPC_SYSTEM:   opgrp_o = GRP_SYSTEM;
      default:      opgrp_o = GRP_NONE;
    endcase
  end

  always_comb begin
    case (opgrp_o)
      GRP_OP, GRP_OP32: fmt_o = FMT_R;
      GRP_LOAD, GRP_OP_IMM, GRP_OP_IMM32, GRP_JALR, GRP_SYSTEM: fmt_o = FMT_I;
      GRP_STORE:          fmt_o = FMT_S;
      GRP_BRANCH:         fmt_o = FMT_B;
      GRP_AUIPC, GRP_LUI: fmt_o = FMT_U;
      GRP_JAL:            fmt_o = FMT_J;
      default:            fmt_o = FMT_NONE;
    endcase
  end

  // funct3 000 is ecall/ebreak/mret, 100 is unused in system
  assign csr_access_o = (opgrp_o == GRP_SYSTEM) && (inst_i.i.funct3[1:0] != 2'b00);
  // csrr*i forms carry uimm in the rs1 slot
  assign csr_imm_valid_o = csr_access_o && inst_i.i.funct3[2];

  assign need_rs1 = (fmt_o inside {FMT_R, FMT_I, FMT_S, FMT_B}) && !csr_imm_valid_o;
  assign need_rs2 = fmt_o inside {FMT_R, FMT_S, FMT_B};
  assign need_rd  = fmt_o inside {FMT_R, FMT_I, FMT_U, FMT_J};

  assign rs1_idx_o = need_rs1 ? inst_i.r.rs1 : '0;
  assign rs2_idx_o = need_rs2 ? inst_i.r.rs2 : '0;
  assign rd_idx_o  = need_rd  ? inst_i.r.rd  : '0;
  assign csr_idx_o = csr_access_o ? inst_i.i.imm11_0 : '0;

endmodule

/* logic/operand_bypass.sv */
`timescale 1ns/1ns
`include "rv_defs.svh"

module operand_bypass import pipe_ctrl_pkg::*; (
  input  logic [`RV_REG_AW-1:0] rs1_idx_i,
  input  logic [`RV_REG_AW-1:0] rs2_idx_i,
  input  logic [`RV_XLEN-1:0]   rs1_data_i,
  input  logic [`RV_XLEN-1:0]   rs2_data_i,
  input  logic [`RV_REG_AW-1:0] ex_rd_addr_i,
  input  logic [`RV_XLEN-1:0]   ex_rd_data_i,
  input  logic [`RV_REG_AW-1:0] mem_rd_addr_i,
  input  logic [`RV_XLEN-1:0]   mem_rd_data_i,
  input  exc_op_e               prev_exc_op_i,
  output logic [`RV_XLEN-1:0]   rs1_fwd_o,
  output logic [`RV_XLEN-1:0]   rs2_fwd_o,
  output logic                  stall_o
);

  logic rs1_ex_hit;
  logic rs2_ex_hit;
  logic rs1_mem_hit;
  logic rs2_mem_hit;

  // x0 is hardwired, never forward into it
  assign rs1_ex_hit  = (rs1_idx_i != '0) && (rs1_idx_i == ex_rd_addr_i);
  assign rs2_ex_hit  = (rs2_idx_i != '0) && (rs2_idx_i == ex_rd_addr_i);
  assign rs1_mem_hit = (rs1_idx_i != '0) && (rs1_idx_i == mem_rd_addr_i);
  assign rs2_mem_hit = (rs2_idx_i != '0) && (rs2_idx_i == mem_rd_addr_i);

  // ex over mem over regfile
  assign rs1_fwd_o = rs1_ex_hit ? ex_rd_data_i : (rs1_mem_hit ? mem_rd_data_i : rs1_data_i);
  assign rs2_fwd_o = rs2_ex_hit ? ex_rd_data_i : (rs2_mem_hit ? mem_rd_data_i : rs2_data_i);

  // load data not ready until mem, hold decode one cycle
  assign stall_o = (prev_exc_op_i == EXC_LOAD) && (rs1_ex_hit || rs2_ex_hit);

endmodule

/* logic/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

  typedef enum logic [4:0] {
    ALU_NONE = 5'd0,
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLW, ALU_SRLW, ALU_SRAW,
    ALU_SLT, ALU_SLTU,
    ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
  } alu_op_e;

  // execute class, also used for the load-use check
  typedef enum logic [3:0] {
    EXC_NONE = 4'd0,
    EXC_AUIPC, EXC_LUI, EXC_JAL, EXC_JALR, EXC_LOAD, EXC_STORE, EXC_BRANCH,
    EXC_OPIMM, EXC_OPIMM32, EXC_OP, EXC_OP32, EXC_CSR, EXC_EBREAK
  } exc_op_e;

  typedef enum logic [3:0] {
    MEM_NONE = 4'd0,
    MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_LWU, MEM_LD,
    MEM_SB, MEM_SH, MEM_SW, MEM_SD
  } mem_op_e;

  typedef enum logic [2:0] {
    PC_INC4 = 3'd0,
    PC_BRANCH, PC_JAL, PC_JALR, PC_TRAP
  } pc_op_e;

  typedef enum logic [2:0] {
    CSR_NONE = 3'd0,
    CSR_READ, CSR_WRITE, CSR_SET, CSR_CLEAR
  } csr_op_e;

  typedef struct packed {
    logic ecall;
    logic ebreak;
    logic mret;
  } trap_flags_t;

endpackage

/* logic/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// architectural widths of the rv64i core
`define RV_XLEN   64
`define RV_REG_AW 5
`define RV_CSR_AW 12
`define RV_INST_W 32

`endif

/* logic/rv_isa_pkg.sv */
package rv_isa_pkg;

  // field layouts of one 32-bit instruction word
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_fmt_t;

  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_fmt_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } rv_s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } rv_b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_j_fmt_t;

  typedef union packed {
    rv_r_fmt_t r;
    rv_i_fmt_t i;
    rv_s_fmt_t s;
    rv_b_fmt_t b;
    rv_u_fmt_t u;
    rv_j_fmt_t j;
  } rv_inst_u;

  // major opcodes kept by this decoder
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;
  localparam logic [6:0] OPC_OP32     = 7'b0111011;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  typedef enum logic [3:0] {
    GRP_NONE, GRP_LOAD, GRP_STORE, GRP_BRANCH, GRP_JALR, GRP_JAL, GRP_OP_IMM,
    GRP_OP, GRP_OP_IMM32, GRP_OP32, GRP_AUIPC, GRP_LUI, GRP_SYSTEM
  } rv_opgrp_e;

  typedef enum logic [2:0] {
    FMT_NONE, FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J
  } rv_fmt_e;

endpackage
